// File: snd_dac_pkg.sv
/*
 * Audio DAC output path shared types
 * PCM samples, offset-binary codes, stereo frames and the register map
 */
package snd_dac_pkg;

    // One PCM sample as delivered by the sound source
    typedef logic [15:0] pcm_t;

    // Unsigned offset-binary code for the modulator
    typedef logic [15:0] dac_code_t;

    // Register port
    typedef logic [1:0] cfg_addr_t;
    typedef logic [7:0] cfg_data_t;

    // Sample period in enable ticks, 0 acts as 1
    typedef logic [7:0] rate_div_t;

    typedef struct packed {
        pcm_t left;
        pcm_t right;
    } snd_frame_t;

    typedef struct packed {
        dac_code_t left;
        dac_code_t right;
    } dac_frame_t;

    typedef struct packed {
        logic      signed_snd;
        logic      mono;
        rate_div_t rate_div;
    } snd_cfg_t;

    // Register map
    localparam cfg_addr_t REG_CTRL   = 2'd0;
    localparam cfg_addr_t REG_RATE   = 2'd1;
    localparam cfg_addr_t REG_STATUS = 2'd2;

    // Values after reset
    localparam rate_div_t RATE_DIV_RST = 8'd16;
    localparam dac_code_t CODE_MID     = 16'h8000;

endpackage

// File: snd_cfg_regs.sv
/*
 * Sound configuration registers
 * Control and rate registers steering the pacer, plus a sticky underrun status
 */
`timescale 1ns/1ps

module snd_cfg_regs (
    input  logic                   clk_dac,
    input  logic                   rst,
    input  logic                   cfg_we_i,
    input  snd_dac_pkg::cfg_addr_t cfg_addr_i,
    input  snd_dac_pkg::cfg_data_t cfg_wdata_i,
    output snd_dac_pkg::cfg_data_t cfg_rdata_o,
    input  logic                   underrun_evt_i,
    output snd_dac_pkg::snd_cfg_t  cfg_o
);
    import snd_dac_pkg::*;

    logic      signed_snd;
    logic      mono;
    rate_div_t rate_div;
    logic      underrun;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            signed_snd <= 1'b0;
            mono       <= 1'b0;
            rate_div   <= RATE_DIV_RST;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == REG_CTRL) begin
                signed_snd <= cfg_wdata_i[0];
                mono       <= cfg_wdata_i[1];
            end
            if (cfg_addr_i == REG_RATE) begin
                rate_div <= cfg_wdata_i;
            end
        end
    end

    // A fresh underrun wins over a clear in the same cycle
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            underrun <= 1'b0;
        end else if (underrun_evt_i) begin
            underrun <= 1'b1;
        end else if (cfg_we_i && cfg_addr_i == REG_STATUS && cfg_wdata_i[0]) begin
            underrun <= 1'b0;
        end
    end

    always_comb begin
        case (cfg_addr_i)
            REG_CTRL:   cfg_rdata_o = {6'd0, mono, signed_snd};
            REG_RATE:   cfg_rdata_o = rate_div;
            REG_STATUS: cfg_rdata_o = {7'd0, underrun};
            default:    cfg_rdata_o = '0;
        endcase
    end

    assign cfg_o.signed_snd = signed_snd;
    assign cfg_o.mono       = mono;
    assign cfg_o.rate_div   = rate_div;

endmodule

// File: snd_sample_fifo.sv
/*
 * Stereo frame FIFO
 * Circular buffer that returns one credit per popped frame
 * and keeps a sticky overflow flag for writes while full
 */
`timescale 1ns/1ps

module snd_sample_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk_dac,
    input  logic                    rst,
    input  logic                    frame_valid_i,
    input  snd_dac_pkg::snd_frame_t frame_i,
    input  logic                    pop_i,
    output logic                    empty_o,
    output snd_dac_pkg::snd_frame_t frame_o,
    output logic                    credit_o,
    output logic                    overflow_o
);
    import snd_dac_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    snd_frame_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          push;
    logic          pop;

    // Wraps at FIFO_DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign full    = (count == CW'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign push    = frame_valid_i && !full;
    assign pop     = pop_i && !empty_o;
    assign frame_o = mem[rd_ptr];

    always_ff @(posedge clk_dac) begin
        if (push) begin
            mem[wr_ptr] <= frame_i;
        end
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_o   <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per freed slot
            credit_o <= pop;
            // Write dropped, flag stays until reset
            if (frame_valid_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

// File: snd_sample_pacer.sv
/*
 * Sample pacer
 * Generates the DAC clock enable, pops one frame per sample period
 * and converts samples to offset-binary codes for the modulators
 */
`timescale 1ns/1ps

module snd_sample_pacer #(
    parameter int CEN_DIV = 4
) (
    input  logic                    clk_dac,
    input  logic                    rst,
    input  snd_dac_pkg::snd_cfg_t   cfg_i,
    input  logic                    empty_i,
    input  snd_dac_pkg::snd_frame_t frame_i,
    output logic                    pop_o,
    output logic                    underrun_o,
    output logic                    cen_o,
    output snd_dac_pkg::dac_frame_t codes_o
);
    import snd_dac_pkg::*;

    logic [CEN_DIV-1:0] cen_sr;
    rate_div_t          tick_cnt;
    rate_div_t          rate_eff;
    logic               boundary;
    dac_code_t          code_left;
    dac_code_t          code_right;

    // Signed input gets its sign bit flipped into offset binary
    function automatic dac_code_t to_code(input pcm_t smp, input logic is_signed);
        return {smp[15] ^ is_signed, smp[14:0]};
    endfunction

    // Rotating one-hot, enable fires on bit 0
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_sr <= CEN_DIV'(1);
        end else begin
            cen_sr <= (cen_sr << 1) | (cen_sr >> (CEN_DIV - 1));
        end
    end

    assign cen_o = cen_sr[0];

    assign rate_eff   = (cfg_i.rate_div == '0) ? rate_div_t'(1) : cfg_i.rate_div;
    assign boundary   = cen_o && (tick_cnt <= rate_div_t'(1));
    assign pop_o      = boundary && !empty_i;
    assign underrun_o = boundary && empty_i;

    // Enable ticks left until the next sample boundary
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            tick_cnt <= RATE_DIV_RST;
        end else if (cen_o) begin
            if (boundary) begin
                tick_cnt <= rate_eff;
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    assign code_left  = to_code(frame_i.left, cfg_i.signed_snd);
    assign code_right = cfg_i.mono ? code_left : to_code(frame_i.right, cfg_i.signed_snd);

    // Codes hold through underruns
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            codes_o <= {CODE_MID, CODE_MID};
        end else if (pop_o) begin
            codes_o.left  <= code_left;
            codes_o.right <= code_right;
        end
    end

endmodule

// File: snd_sd_mod.sv
/*
 * First-order sigma-delta modulator
 * Accumulates the code on each enable and outputs the carry as a PWM bit
 */
`timescale 1ns/1ps

module snd_sd_mod (
    input  logic                   clk_dac,
    input  logic                   rst,
    input  logic                   cen_i,
    input  snd_dac_pkg::dac_code_t code_i,
    output logic                   pwm_o
);
    import snd_dac_pkg::*;

    localparam int CW = $bits(dac_code_t);

    dac_code_t acc;
    logic [CW:0] sum;

    // Carry out is the density bit
    assign sum = {1'b0, acc} + {1'b0, code_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            pwm_o <= 1'b0;
        end else if (cen_i) begin
            acc   <= sum[CW-1:0];
            pwm_o <= sum[CW];
        end
    end

endmodule

// File: snd_dac_top.sv
/*
 * Audio output path top level
 * Registers, sample FIFO, pacer and one modulator per channel on clk_dac
 */
`timescale 1ns/1ps

module snd_dac_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int CEN_DIV    = 4
) (
    input  logic                    clk_dac,
    input  logic                    rst,
    // Frame source
    input  logic                    frame_valid_i,
    input  snd_dac_pkg::snd_frame_t frame_i,
    output logic                    credit_o,
    output logic                    overflow_o,
    // Register port
    input  logic                    cfg_we_i,
    input  snd_dac_pkg::cfg_addr_t  cfg_addr_i,
    input  snd_dac_pkg::cfg_data_t  cfg_wdata_i,
    output snd_dac_pkg::cfg_data_t  cfg_rdata_o,
    // PWM pins
    output logic                    snd_pwm_left_o,
    output logic                    snd_pwm_right_o
);
    import snd_dac_pkg::*;

    snd_cfg_t   cfg;
    logic       underrun_evt;
    logic       fifo_empty;
    snd_frame_t fifo_frame;
    logic       fifo_pop;
    logic       cen;
    dac_frame_t codes;

    snd_cfg_regs u_cfg_regs (
        .clk_dac        ( clk_dac      ),
        .rst            ( rst          ),
        .cfg_we_i       ( cfg_we_i     ),
        .cfg_addr_i     ( cfg_addr_i   ),
        .cfg_wdata_i    ( cfg_wdata_i  ),
        .cfg_rdata_o    ( cfg_rdata_o  ),
        .underrun_evt_i ( underrun_evt ),
        .cfg_o          ( cfg          )
    );

    snd_sample_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .clk_dac       ( clk_dac       ),
        .rst           ( rst           ),
        .frame_valid_i ( frame_valid_i ),
        .frame_i       ( frame_i       ),
        .pop_i         ( fifo_pop      ),
        .empty_o       ( fifo_empty    ),
        .frame_o       ( fifo_frame    ),
        .credit_o      ( credit_o      ),
        .overflow_o    ( overflow_o    )
    );

    snd_sample_pacer #(
        .CEN_DIV ( CEN_DIV )
    ) u_pacer (
        .clk_dac    ( clk_dac      ),
        .rst        ( rst          ),
        .cfg_i      ( cfg          ),
        .empty_i    ( fifo_empty   ),
        .frame_i    ( fifo_frame   ),
        .pop_o      ( fifo_pop     ),
        .underrun_o ( underrun_evt ),
        .cen_o      ( cen          ),
        .codes_o    ( codes        )
    );

    snd_sd_mod u_mod_left (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .cen_i   ( cen            ),
        .code_i  ( codes.left     ),
        .pwm_o   ( snd_pwm_left_o )
    );

    snd_sd_mod u_mod_right (
        .clk_dac ( clk_dac         ),
        .rst     ( rst             ),
        .cen_i   ( cen             ),
        .code_i  ( codes.right     ),
        .pwm_o   ( snd_pwm_right_o )
    );

endmodule

// File: snd_dac_checker.sv
/*
 * Bound assertions for the audio output path
 * Credit pulse width, sticky overflow and the outstanding credit bound
 */
`timescale 1ns/1ps

module snd_dac_checker #(
    parameter int FIFO_DEPTH = 4
) (
    input logic clk_dac,
    input logic rst,
    input logic frame_valid_i,
    input logic credit_i,
    input logic overflow_i
);
    // Cleared from the testbench before a write that breaks the credit rule
    logic chk_en = 1'b1;
    int   outstanding;

    // Frames written with the checks enabled and not yet credited back
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + ((frame_valid_i && chk_en) ? 1 : 0)
                           - (credit_i ? 1 : 0);
        end
    end

    credit_one_cycle: assert property (@(posedge clk_dac) disable iff (rst || !chk_en)
        credit_i |=> !credit_i)
        else $error("credit_o held high for more than one cycle");

    overflow_sticky: assert property (@(posedge clk_dac) disable iff (rst || !chk_en)
        !$fell(overflow_i))
        else $error("overflow_o fell outside reset");

    credit_bound: assert property (@(posedge clk_dac) disable iff (rst || !chk_en)
        outstanding <= FIFO_DEPTH)
        else $error("outstanding frames exceed FIFO depth");

endmodule

bind snd_dac_top snd_dac_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (
    .clk_dac       ( clk_dac       ),
    .rst           ( rst           ),
    .frame_valid_i ( frame_valid_i ),
    .credit_i      ( credit_o      ),
    .overflow_i    ( overflow_o    )
);

// File: tb_snd_dac.sv
/*
 * Testbench for the audio output path
 * Table of sample formats checked through PWM density, then
 * credit accounting, underrun status and overflow
 */
`timescale 1ns/1ps

module tb_snd_dac;
    import snd_dac_pkg::*;

    localparam int        FIFO_DEPTH = 4;
    localparam int        CEN_DIV    = 4;
    localparam int        TICK_PH    = 1 % CEN_DIV;
    localparam int        PWM_TICKS  = 256;
    localparam int        TIMEOUT    = 4000;
    localparam int        NUM_VEC    = 8;
    localparam cfg_data_t RATE       = 8'd4;

    typedef struct packed {
        logic      is_signed;
        logic      mono;
        pcm_t      left;
        pcm_t      right;
        dac_code_t exp_left;
        dac_code_t exp_right;
    } vec_t;

    logic       clk_dac;
    logic       rst;
    logic       frame_valid_i;
    snd_frame_t frame_i;
    logic       credit_o;
    logic       overflow_o;
    logic       cfg_we_i;
    cfg_addr_t  cfg_addr_i;
    cfg_data_t  cfg_wdata_i;
    cfg_data_t  cfg_rdata_o;
    logic       snd_pwm_left_o;
    logic       snd_pwm_right_o;

    vec_t vec_tab [NUM_VEC];
    int   phase;
    int   sent;
    int   received;

    snd_dac_top #(
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .CEN_DIV    ( CEN_DIV    )
    ) u_dut (
        .clk_dac         ( clk_dac         ),
        .rst             ( rst             ),
        .frame_valid_i   ( frame_valid_i   ),
        .frame_i         ( frame_i         ),
        .credit_o        ( credit_o        ),
        .overflow_o      ( overflow_o      ),
        .cfg_we_i        ( cfg_we_i        ),
        .cfg_addr_i      ( cfg_addr_i      ),
        .cfg_wdata_i     ( cfg_wdata_i     ),
        .cfg_rdata_o     ( cfg_rdata_o     ),
        .snd_pwm_left_o  ( snd_pwm_left_o  ),
        .snd_pwm_right_o ( snd_pwm_right_o )
    );

    initial begin
        clk_dac = 1'b0;
        forever #50 clk_dac = ~clk_dac;
    end

    // Enable phase rebuilt from rising edges, first tick right after reset
    always @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            phase <= 0;
        end else begin
            phase <= (phase == CEN_DIV - 1) ? 0 : phase + 1;
        end
    end

    always @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            received <= 0;
        end else if (credit_o) begin
            received <= received + 1;
        end
    end

    // Offset binary: flip the sign bit of signed samples
    function automatic dac_code_t offset_code(input pcm_t smp, input logic is_signed);
        return is_signed ? (smp ^ 16'h8000) : smp;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    // PWM density as highs*256 against the code, within one count
    task automatic check_code(input string name, input int highs, input dac_code_t exp);
        int got;
        int diff;
        got  = highs * 256;
        diff = got - int'(exp);
        if (diff <= -256 || diff >= 256) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input cfg_data_t got, input cfg_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_tick();
        int t;
        t = 0;
        do begin
            @(negedge clk_dac);
            t++;
        end while (phase != TICK_PH && t <= CEN_DIV);
        if (phase != TICK_PH) begin
            fail_run("enable tick phase was not found");
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge clk_dac);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        @(negedge clk_dac);
        cfg_we_i    = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(negedge clk_dac);
        cfg_addr_i = addr;
        @(negedge clk_dac);
        data = cfg_rdata_o;
    endtask

    // Source side, one frame per held credit
    task automatic send_frame(input snd_frame_t f);
        int t;
        t = 0;
        @(negedge clk_dac);
        while (FIFO_DEPTH - sent + received <= 0 && t < TIMEOUT) begin
            @(negedge clk_dac);
            t++;
        end
        if (FIFO_DEPTH - sent + received <= 0) begin
            fail_run("no credit came back for the next frame");
        end
        frame_valid_i = 1'b1;
        frame_i       = f;
        sent++;
        @(negedge clk_dac);
        frame_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (received != sent && t < TIMEOUT) begin
            @(negedge clk_dac);
            t++;
        end
        if (received != sent) begin
            fail_run("FIFO did not drain, credits are missing");
        end
    endtask

    task automatic count_pwm(output int high_l, output int high_r);
        high_l = 0;
        high_r = 0;
        repeat (PWM_TICKS) begin
            wait_tick();
            if (snd_pwm_left_o) high_l++;
            if (snd_pwm_right_o) high_r++;
        end
    endtask

    initial begin
        int         i;
        int         cnt_l;
        int         cnt_r;
        vec_t       v;
        snd_frame_t f;
        cfg_data_t  rd;

        rst           = 1'b1;
        frame_valid_i = 1'b0;
        frame_i       = '0;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = REG_CTRL;
        cfg_wdata_i   = '0;
        sent          = 0;
        void'($urandom(32'h7ceb));

        // {signed, mono, left, right, left code, right code}
        vec_tab[0] = '{1'b0, 1'b0, 16'h8000, 16'h8000, 16'h8000, 16'h8000};
        vec_tab[1] = '{1'b0, 1'b0, 16'h0000, 16'hFFFF, 16'h0000, 16'hFFFF};
        vec_tab[2] = '{1'b1, 1'b0, 16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000};
        vec_tab[3] = '{1'b1, 1'b0, 16'h0000, 16'h1234, 16'h8000, 16'h9234};
        vec_tab[4] = '{1'b0, 1'b1, 16'h4000, 16'hC000, 16'h4000, 16'h4000};
        vec_tab[5] = '{1'b1, 1'b1, 16'hC000, 16'h1111, 16'h4000, 16'h4000};
        for (i = 6; i < NUM_VEC; i++) begin
            v.is_signed = (i == 7);
            v.mono      = 1'b0;
            v.left      = pcm_t'($urandom);
            v.right     = pcm_t'($urandom);
            v.exp_left  = offset_code(v.left, v.is_signed);
            v.exp_right = offset_code(v.right, v.is_signed);
            vec_tab[i]  = v;
        end

        repeat (16) @(posedge clk_dac);
        @(negedge clk_dac);
        rst = 1'b0;

        check_bit("credit_o", credit_o, 1'b0);
        check_bit("overflow_o", overflow_o, 1'b0);
        check_bit("snd_pwm_left_o", snd_pwm_left_o, 1'b0);
        check_bit("snd_pwm_right_o", snd_pwm_right_o, 1'b0);
        read_reg(REG_RATE, rd);
        check_reg("cfg_rdata_o REG_RATE", rd, 8'd16);
        read_reg(REG_STATUS, rd);
        check_reg("cfg_rdata_o REG_STATUS", rd, 8'd0);

        write_reg(REG_RATE, RATE);
        for (i = 0; i < NUM_VEC; i++) begin
            v = vec_tab[i];
            f = '{left: v.left, right: v.right};
            write_reg(REG_CTRL, {6'd0, v.mono, v.is_signed});
            repeat (FIFO_DEPTH) send_frame(f);
            wait_drain();
            repeat (RATE) wait_tick();
            count_pwm(cnt_l, cnt_r);
            check_code("snd_pwm_left_o", cnt_l, v.exp_left);
            check_code("snd_pwm_right_o", cnt_r, v.exp_right);
        end
        check_count("credit_o pulses", received, sent);
        check_bit("overflow_o", overflow_o, 1'b0);

        // Underrun holds the last codes
        f = '{left: 16'h6000, right: 16'hA000};
        write_reg(REG_CTRL, 8'h00);
        send_frame(f);
        wait_drain();
        repeat (int'(RATE) + 1) wait_tick();
        read_reg(REG_STATUS, rd);
        check_reg("cfg_rdata_o REG_STATUS", rd, 8'h01);
        count_pwm(cnt_l, cnt_r);
        check_code("snd_pwm_left_o", cnt_l, 16'h6000);
        check_code("snd_pwm_right_o", cnt_r, 16'hA000);
        // Clear right after a pop, well before the next boundary
        send_frame(f);
        wait_drain();
        write_reg(REG_STATUS, 8'h01);
        read_reg(REG_STATUS, rd);
        check_reg("cfg_rdata_o REG_STATUS", rd, 8'h00);

        // Long sample period so the FIFO stays full
        write_reg(REG_RATE, 8'd255);
        repeat (int'(RATE) + 1) wait_tick();
        repeat (FIFO_DEPTH) send_frame(f);
        check_bit("overflow_o", overflow_o, 1'b0);
        u_dut.u_checker.chk_en = 1'b0;
        @(negedge clk_dac);
        frame_valid_i = 1'b1;
        @(negedge clk_dac);
        frame_valid_i = 1'b0;
        check_bit("overflow_o", overflow_o, 1'b1);

        // Overflow stays set with the assertions watching again
        u_dut.u_checker.chk_en = 1'b1;
        repeat (CEN_DIV * 4) @(negedge clk_dac);
        check_bit("overflow_o", overflow_o, 1'b1);

        $display("No errors");
        $finish;
    end

endmodule

// File: snd_dac_top.f
snd_dac_pkg.sv
snd_cfg_regs.sv
snd_sample_fifo.sv
snd_sample_pacer.sv
snd_sd_mod.sv
snd_dac_top.sv
snd_dac_checker.sv
tb_snd_dac.sv

// File: run.sh
#!/bin/sh
# Compile and run the audio output path testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_snd_dac -f snd_dac_top.f &&
./obj_dir/Vtb_snd_dac | tee /dev/stderr | grep -qx "No errors" ||
{ echo "simulation failed" >&2; exit 1; }
